/* include/alu_config.svh */
/*
 * Size and flag layout constants for the ALU.
 * Included by the package, the RTL and the testbench.
 */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Datapath widths
`define ALU_WIDTH      16 // Full word
`define ALU_BYTE_WIDTH 8  // Byte-size operations use the low byte

// Operation code width, wide enough for all ops
`define ALU_OP_BITS    5

// Condition codes, X N Z V C
`define ALU_CCR_BITS   5

// Bit positions inside the flag vector
`define ALU_CF 0 // Carry
`define ALU_VF 1 // Overflow
`define ALU_ZF 2 // Zero
`define ALU_NF 3 // Negative
`define ALU_XF 4 // Extend

`endif

/* hw/aluPkg.sv */
/*
 * Shared types for the ALU: the operation code and the flag vector.
 * Modules take them with a wildcard import in the module header.
 */
`default_nettype none

`include "alu_config.svh"

package aluPkg;

	// Operation codes as presented by the host
	typedef enum logic [`ALU_OP_BITS-1:0] {
		opAnd,   // Logic group
		opOr,
		opEor,
		opAdd,   // Adder group, sub is D - A
		opAddx,  // X as carry in, sticky Z
		opSub,
		opSubx,  // X as borrow in, sticky Z
		opLsl,   // Shift group, one bit on A
		opLsr,
		opAsl,
		opAsr,
		opRol,   // Rotates leave X alone
		opRor,
		opRoxl,  // Rotate through X
		opRoxr
	} aluOp_t;

	// Flag vector X N Z V C
	// Index with the ALU_*F position macros
	typedef logic [`ALU_CCR_BITS-1:0] ccr_t;

endpackage

`default_nettype wire

/* hw/aluArith.sv */
/*
 * Combinational logic unit and adder/subtractor.
 * Drives the result and flag contributions for AND/OR/EOR and the ADD/SUB family;
 * the merge stage picks these up when arithHit is set.
 */
`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module aluArith import aluPkg::*; (
	input  aluOp_t                op,
	input  logic                  isByte,
	input  logic [`ALU_WIDTH-1:0] aOperand,
	input  logic [`ALU_WIDTH-1:0] dOperand,
	input  logic                  xIn,       // Registered X flag
	output logic                  arithHit,
	output logic [`ALU_WIDTH-1:0] arithResult,
	output logic                  arithNeg,
	output logic                  arithZero,
	output logic                  arithCarry,
	output logic                  arithOverflow,
	output logic                  arithSetsX,
	output logic                  stickyZ
);

	localparam int W  = `ALU_WIDTH;
	localparam int BW = `ALU_BYTE_WIDTH;

	logic          isLogic, isAddSub, isAdd;
	logic          carryIn;
	logic [W:0]    wordSum;    // Extra bit holds carry or borrow
	logic [BW:0]   byteSum;
	logic [W-1:0]  rawResult;  // Before size masking
	logic          resMsb, dMsb, aMsb;

	// Op group decode
	assign isLogic  = (op == opAnd) || (op == opOr) || (op == opEor);
	assign isAdd    = (op == opAdd) || (op == opAddx);
	assign isAddSub = isAdd || (op == opSub) || (op == opSubx);
	assign stickyZ  = (op == opAddx) || (op == opSubx);
	assign carryIn  = stickyZ ? xIn : 1'b0; // Only X variants chain
	assign arithHit = isLogic || isAddSub;

	// Both widths computed, size picks one
	always_comb begin
		if (isAdd) begin
			wordSum = {1'b0, dOperand} + {1'b0, aOperand} + carryIn;
			byteSum = {1'b0, dOperand[BW-1:0]} + {1'b0, aOperand[BW-1:0]} + carryIn;
		end else begin
			wordSum = {1'b0, dOperand} - {1'b0, aOperand} - carryIn; // D minus A
			byteSum = {1'b0, dOperand[BW-1:0]} - {1'b0, aOperand[BW-1:0]} - carryIn;
		end
	end

	always_comb begin
		case (op)
			opAnd:   rawResult = aOperand & dOperand;
			opOr:    rawResult = aOperand | dOperand;
			opEor:   rawResult = aOperand ^ dOperand;
			default: rawResult = wordSum[W-1:0]; // Low byte matches byteSum
		endcase
	end

	// Upper byte cleared in byte mode
	assign arithResult = isByte ? {{(W-BW){1'b0}}, rawResult[BW-1:0]} : rawResult;

	// Sign bits at the size boundary
	assign resMsb = isByte ? rawResult[BW-1] : rawResult[W-1];
	assign dMsb   = isByte ? dOperand[BW-1]  : dOperand[W-1];
	assign aMsb   = isByte ? aOperand[BW-1]  : aOperand[W-1];

	assign arithNeg  = resMsb;
	assign arithZero = isByte ? ~|rawResult[BW-1:0] : ~|rawResult;

	always_comb begin
		arithCarry    = 1'b0;  // Logic ops clear C and V
		arithOverflow = 1'b0;
		arithSetsX    = 1'b0;
		if (isAddSub) begin
			arithCarry = isByte ? byteSum[BW] : wordSum[W];
			arithSetsX = 1'b1; // X follows C
			// Add: like signs in, other sign out. Sub: unlike signs in, D sign lost
			if (isAdd)
				arithOverflow = (aMsb == dMsb) && (resMsb != dMsb);
			else
				arithOverflow = (aMsb != dMsb) && (resMsb != dMsb);
		end
	end

endmodule

`default_nettype wire

/* hw/aluShifter.sv */
/*
 * Combinational one-bit shift and rotate unit working on operand A.
 * Picks direction and fill per op and reports carry-out, ASL overflow and
 * whether X takes the bit shifted out.
 */
`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module aluShifter import aluPkg::*; (
	input  aluOp_t                op,
	input  logic                  isByte,
	input  logic [`ALU_WIDTH-1:0] aOperand,
	input  logic                  xIn,       // Fill for ROXL/ROXR
	output logic                  shiftHit,
	output logic [`ALU_WIDTH-1:0] shiftResult,
	output logic                  shiftNeg,
	output logic                  shiftZero,
	output logic                  shiftCarry,
	output logic                  shiftOverflow,
	output logic                  shiftSetsX
);

	localparam int W  = `ALU_WIDTH;
	localparam int BW = `ALU_BYTE_WIDTH;

	logic          rightDir;
	logic          fillBit;
	logic          srcMsb;     // Top bit at the size boundary
	logic          srcLsb;
	logic          newMsb;
	logic [W-1:0]  shifted;

	assign srcMsb = isByte ? aOperand[BW-1] : aOperand[W-1];
	assign srcLsb = aOperand[0];

	// Group and direction decode
	always_comb begin
		shiftHit = 1'b1;
		rightDir = 1'b0;
		case (op)
			opLsl, opAsl, opRol, opRoxl: rightDir = 1'b0;
			opLsr, opAsr, opRor, opRoxr: rightDir = 1'b1;
			default:                     shiftHit = 1'b0; // Not a shift
		endcase
	end

	// Bit entering the vacated end
	always_comb begin
		case (op)
			opAsr:        fillBit = srcMsb;  // Sign extend
			opRol:        fillBit = srcMsb;  // Wrap around
			opRor:        fillBit = srcLsb;
			opRoxl,
			opRoxr:       fillBit = xIn;     // Through X
			default:      fillBit = 1'b0;    // LSL, LSR, ASL
		endcase
	end

	always_comb begin
		if (rightDir) begin
			shifted = {1'b0, aOperand[W-1:1]};
			// Fill lands at bit 7 or bit 15 depending on size
			if (isByte)
				shifted[BW-1] = fillBit;
			else
				shifted[W-1] = fillBit;
		end else begin
			shifted = {aOperand[W-2:0], fillBit};
		end
	end

	// Clear the upper byte for byte ops
	assign shiftResult = isByte ? {{(W-BW){1'b0}}, shifted[BW-1:0]} : shifted;

	assign newMsb    = isByte ? shifted[BW-1] : shifted[W-1];
	assign shiftNeg  = newMsb;
	assign shiftZero = isByte ? ~|shifted[BW-1:0] : ~|shifted;

	// Bit shifted out goes to C
	assign shiftCarry = rightDir ? srcLsb : srcMsb;

	// ASL flags a sign change, every other shift clears V
	assign shiftOverflow = (op == opAsl) ? (srcMsb ^ newMsb) : 1'b0;

	// Plain rotates keep X
	assign shiftSetsX = shiftHit && (op != opRol) && (op != opRor);

endmodule

`default_nettype wire

/* hw/aluFlagMerge.sv */
/*
 * Result and condition-code stage. Chooses between the logic/adder unit and
 * the shifter by their hit bits, forms the new X N Z V C, and registers result,
 * flags and done. The registered flags feed X back to both units.
 */
`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module aluFlagMerge import aluPkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,          // Op valid this cycle
	input  logic                  ccrLoad,        // Direct flag load strobe
	input  ccr_t                  ccrIn,

	// Logic/adder unit
	input  logic                  arithHit,
	input  logic [`ALU_WIDTH-1:0] arithResult,
	input  logic                  arithNeg,
	input  logic                  arithZero,
	input  logic                  arithCarry,
	input  logic                  arithOverflow,
	input  logic                  arithSetsX,
	input  logic                  stickyZ,

	// Shifter
	input  logic                  shiftHit,
	input  logic [`ALU_WIDTH-1:0] shiftResult,
	input  logic                  shiftNeg,
	input  logic                  shiftZero,
	input  logic                  shiftCarry,
	input  logic                  shiftOverflow,
	input  logic                  shiftSetsX,

	output logic [`ALU_WIDTH-1:0] result,
	output ccr_t                  ccr,
	output logic                  done
);

	logic [`ALU_WIDTH-1:0] selResult;
	logic                  selNeg, selZero, selCarry, selOverflow, selSetsX;
	logic                  anyHit;
	ccr_t                  nextCcr;

	assign anyHit = arithHit || shiftHit;

	// Source select, no op decode here
	always_comb begin
		selResult   = '0;
		selNeg      = 1'b0;
		selZero     = 1'b0;
		selCarry    = 1'b0;
		selOverflow = 1'b0;
		selSetsX    = 1'b0;
		if (shiftHit) begin
			selResult   = shiftResult;
			selNeg      = shiftNeg;
			selZero     = shiftZero;
			selCarry    = shiftCarry;
			selOverflow = shiftOverflow;
			selSetsX    = shiftSetsX;
		end else if (arithHit) begin
			selResult   = arithResult;
			selNeg      = arithNeg;
			selZero     = arithZero;
			selCarry    = arithCarry;
			selOverflow = arithOverflow;
			selSetsX    = arithSetsX;
		end
	end

	// New flags from the chosen unit
	always_comb begin
		nextCcr = ccr; // Unknown op leaves flags alone
		if (anyHit) begin
			nextCcr[`ALU_NF] = selNeg;
			nextCcr[`ALU_VF] = selOverflow;
			nextCcr[`ALU_CF] = selCarry;
			// ADDX/SUBX only clear Z, so multiword zero tests work
			if (arithHit && stickyZ)
				nextCcr[`ALU_ZF] = ccr[`ALU_ZF] & selZero;
			else
				nextCcr[`ALU_ZF] = selZero;
			nextCcr[`ALU_XF] = selSetsX ? selCarry : ccr[`ALU_XF];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			ccr    <= '0;
			done   <= 1'b0;
		end else begin
			done <= start; // One cycle after start
			if (start)
				result <= selResult;
			// Host load beats the op's flags
			if (ccrLoad)
				ccr <= ccrIn;
			else if (start)
				ccr <= nextCcr;
		end
	end

endmodule

`default_nettype wire

/* hw/aluTop.sv */
/*
 * ALU top level. The logic/adder unit and the shifter run side by side on
 * the host operands; the merge stage registers the winner one cycle later.
 */
`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module aluTop import aluPkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  aluOp_t                op,
	input  logic                  isByte,
	input  logic [`ALU_WIDTH-1:0] aOperand,  // Shift source, subtrahend
	input  logic [`ALU_WIDTH-1:0] dOperand,  // Minuend
	input  logic                  ccrLoad,
	input  ccr_t                  ccrIn,
	output logic [`ALU_WIDTH-1:0] result,
	output ccr_t                  ccr,
	output logic                  done
);

	// Logic/adder unit outputs
	logic                  arithHit;
	logic [`ALU_WIDTH-1:0] arithResult;
	logic                  arithNeg, arithZero, arithCarry, arithOverflow;
	logic                  arithSetsX;
	logic                  stickyZ;

	// Shifter outputs
	logic                  shiftHit;
	logic [`ALU_WIDTH-1:0] shiftResult;
	logic                  shiftNeg, shiftZero, shiftCarry, shiftOverflow;
	logic                  shiftSetsX;

	aluArith arith (
		.op, .isByte, .aOperand, .dOperand,
		.xIn(ccr[`ALU_XF]),  // Registered X
		.arithHit, .arithResult, .arithNeg, .arithZero,
		.arithCarry, .arithOverflow, .arithSetsX, .stickyZ
	);

	aluShifter shifter (
		.op, .isByte, .aOperand,
		.xIn(ccr[`ALU_XF]),
		.shiftHit, .shiftResult, .shiftNeg, .shiftZero,
		.shiftCarry, .shiftOverflow, .shiftSetsX
	);

	aluFlagMerge merge (
		.clk, .reset, .start, .ccrLoad, .ccrIn,
		.arithHit, .arithResult, .arithNeg, .arithZero,
		.arithCarry, .arithOverflow, .arithSetsX, .stickyZ,
		.shiftHit, .shiftResult, .shiftNeg, .shiftZero,
		.shiftCarry, .shiftOverflow, .shiftSetsX,
		.result, .ccr, .done
	);

endmodule

`default_nettype wire

/* tb/aluChecker.sv */
/*
 * Watches the ALU ports and keeps its own flag model. Predicts result, flags
 * and done for every cycle, prints a line per test and keeps the totals.
 */
`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module aluChecker import aluPkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  aluOp_t                op,
	input  logic                  isByte,
	input  logic [`ALU_WIDTH-1:0] aOperand,
	input  logic [`ALU_WIDTH-1:0] dOperand,
	input  logic                  ccrLoad,
	input  ccr_t                  ccrIn,
	input  logic [`ALU_WIDTH-1:0] result,
	input  ccr_t                  ccr,
	input  logic                  done,
	input  logic [2:0]            testId,     // Current test from the testbench
	output int                    errCount,
	output int                    checkCount
);

	localparam int PAD = `ALU_WIDTH - `ALU_CCR_BITS;

	logic [`ALU_WIDTH-1:0] expResult, nextResult;
	ccr_t                  expCcr, nextCcr;   // expCcr doubles as the model flag register
	logic                  expDone;
	logic                  armed;             // Set once a prediction exists
	logic [2:0]            lastId;
	int                    testChecks, testErrors;

	function automatic string testName(input logic [2:0] id);
		case (id)
			3'd0:    return "reset";
			3'd1:    return "logic";
			3'd2:    return "addsub";
			3'd3:    return "extend";
			3'd4:    return "shift";
			3'd5:    return "mixed";
			default: return "end";
		endcase
	endfunction

	// One op worked out on plain integers
	task automatic predict(input aluOp_t o, input logic sz, input logic [`ALU_WIDTH-1:0] a,
			input logic [`ALU_WIDTH-1:0] d, input ccr_t old,
			output logic [`ALU_WIDTH-1:0] r, output ccr_t f);
		int   n, mask, ua, ud, sa, sd, rr, sum, ss, cin;
		logic c, v, x, extOp;
		n     = sz ? `ALU_BYTE_WIDTH : `ALU_WIDTH;
		mask  = (1 << n) - 1;
		ua    = int'(a) & mask;
		ud    = int'(d) & mask;
		sa    = ua[n-1] ? ua - (1 << n) : ua;  // Signed views
		sd    = ud[n-1] ? ud - (1 << n) : ud;
		extOp = (o == opAddx) || (o == opSubx);
		cin   = extOp && old[`ALU_XF] ? 1 : 0;
		c     = 1'b0;
		v     = 1'b0;
		x     = old[`ALU_XF];                   // Logic ops keep X
		rr    = 0;
		case (o)
			opAnd: rr = ua & ud;
			opOr:  rr = ua | ud;
			opEor: rr = ua ^ ud;
			opAdd, opAddx, opSub, opSubx: begin
				if (o == opAdd || o == opAddx) begin
					sum = ud + ua + cin;
					ss  = sd + sa + cin;
					c   = sum > mask;               // Carry out
				end else begin
					sum = ud - ua - cin;            // D minus A
					ss  = sd - sa - cin;
					c   = sum < 0;                  // Borrow
				end
				rr = sum & mask;
				v  = (ss > (1 << (n-1)) - 1) || (ss < -(1 << (n-1)));  // Out of signed range
				x  = c;
			end
			opLsl, opAsl, opRol, opRoxl: begin
				c  = ua[n-1];
				rr = (ua << 1) & mask;
				if (o == opRol)
					rr[0] = c;
				if (o == opRoxl)
					rr[0] = old[`ALU_XF];
				if (o == opAsl)
					v = c ^ rr[n-1];                // Sign changed
				if (o != opRol)
					x = c;
			end
			default: begin                      // Right shifts and rotates
				c  = ua[0];
				rr = ua >> 1;
				case (o)
					opAsr:   rr[n-1] = ua[n-1];
					opRor:   rr[n-1] = c;
					opRoxr:  rr[n-1] = old[`ALU_XF];
					default: rr[n-1] = 1'b0;
				endcase
				if (o != opRor)
					x = c;
			end
		endcase
		r          = rr[`ALU_WIDTH-1:0];
		f[`ALU_CF] = c;
		f[`ALU_VF] = v;
		f[`ALU_NF] = rr[n-1];
		f[`ALU_ZF] = extOp ? old[`ALU_ZF] && (rr == 0) : (rr == 0);  // Sticky for X ops
		f[`ALU_XF] = x;
	endtask

	task automatic compare(input string field, input logic [`ALU_WIDTH-1:0] expV,
			input logic [`ALU_WIDTH-1:0] actV);
		checkCount++;
		testChecks++;
		if (actV !== expV) begin
			errCount++;
			testErrors++;
			$display("Mismatch in test %s: %s expected %h, actual %h at %0t",
				testName(lastId), field, expV, actV, $time);
		end
	endtask

	initial begin
		armed      = 1'b0;
		errCount   = 0;
		checkCount = 0;
		testChecks = 0;
		testErrors = 0;
		lastId     = 3'd0;
	end

	// Outputs and the next inputs are both settled at the falling edge
	always @(negedge clk) begin
		if (testId != lastId) begin
			$display("Test %s: %0d checks, %0d errors", testName(lastId), testChecks, testErrors);
			testChecks = 0;
			testErrors = 0;
			lastId     = testId;
		end
		if (armed) begin
			compare("result", expResult, result);
			compare("ccr", {{PAD{1'b0}}, expCcr}, {{PAD{1'b0}}, ccr});
			compare("done", {{(`ALU_WIDTH-1){1'b0}}, expDone}, {{(`ALU_WIDTH-1){1'b0}}, done});
		end
		if (reset) begin
			expResult = '0;
			expCcr    = '0;
			expDone   = 1'b0;
		end else begin
			predict(op, isByte, aOperand, dOperand, expCcr, nextResult, nextCcr);
			expDone = start;
			if (start)
				expResult = nextResult;
			if (ccrLoad)                        // Host load beats the op
				expCcr = ccrIn;
			else if (start)
				expCcr = nextCcr;
		end
		armed = 1'b1;
	end

endmodule

`default_nettype wire

/* tb/aluTb.sv */
/*
 * Testbench for the ALU top level. Drives seeded random ops 1 ns after each
 * rising edge; aluChecker predicts and compares every cycle.
 */
`timescale 1ns/100ps
`default_nettype none

`include "alu_config.svh"

module aluTb import aluPkg::*; ();

	localparam int W            = `ALU_WIDTH;
	localparam int DONE_TIMEOUT = 20;          // Cycles

	logic         clk, reset, start, isByte, ccrLoad, done;
	aluOp_t       op;
	logic [W-1:0] aOperand, dOperand, result;
	ccr_t         ccrIn, ccr;
	logic [2:0]   testId;
	int           errCount, checkCount, timeouts;
	int           seed;

	aluTop uut (
		.clk, .reset, .start, .op, .isByte, .aOperand, .dOperand,
		.ccrLoad, .ccrIn, .result, .ccr, .done
	);

	aluChecker check (
		.clk, .reset, .start, .op, .isByte, .aOperand, .dOperand,
		.ccrLoad, .ccrIn, .result, .ccr, .done,
		.testId, .errCount, .checkCount
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Mostly random, with sign and carry corner values mixed in
	task automatic randomOperand(output logic [W-1:0] v);
		logic [31:0] rnd;
		rnd = $random(seed);
		case (rnd[19:17])
			3'd0:    v = rnd[16] ? 16'h7fff : 16'h007f;
			3'd1:    v = rnd[16] ? 16'h8000 : 16'h0080;
			3'd2:    v = 16'hffff;
			3'd3:    v = 16'h0000;
			default: v = rnd[W-1:0];
		endcase
	endtask

	// Groups 0 logic, 1 add/sub, 2 shift, 3 extend, 4 any
	task automatic pickOp(input int group, output aluOp_t o);
		logic [31:0] rnd;
		int          grp;
		rnd = $random(seed);
		grp = (group == 4) ? int'(rnd[9:8]) : group;
		case (grp)
			0:       o = (rnd[2:0] < 3'd3) ? opAnd : (rnd[2] ? opOr : opEor);
			1:       o = rnd[0] ? opSub : opAdd;
			3:       o = rnd[0] ? opSubx : opAddx;
			default: begin
				case (rnd[2:0])
					3'd0:    o = opLsl;
					3'd1:    o = opLsr;
					3'd2:    o = opAsl;
					3'd3:    o = opAsr;
					3'd4:    o = opRol;
					3'd5:    o = opRor;
					3'd6:    o = opRoxl;
					default: o = opRoxr;
				endcase
			end
		endcase
	endtask

	// One start pulse, with a random flag value on ccrIn
	task automatic applyOp(input aluOp_t o, input logic sz, input logic [W-1:0] a,
			input logic [W-1:0] d, input logic load);
		logic [31:0] rnd;
		rnd      = $random(seed);
		op       = o;
		isByte   = sz;
		aOperand = a;
		dOperand = d;
		start    = 1'b1;
		ccrLoad  = load;
		ccrIn    = rnd[`ALU_CCR_BITS-1:0];
		@(posedge clk);
		#1;
		start    = 1'b0;
		ccrLoad  = 1'b0;
	endtask

	task automatic applyLoad(input ccr_t v);
		ccrLoad = 1'b1;
		ccrIn   = v;
		@(posedge clk);
		#1;
		ccrLoad = 1'b0;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Done for the last start, then one idle cycle
	task automatic waitDone();
		int cycles;
		cycles = 0;
		while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (done !== 1'b1) begin
			$display("Timeout: no done within %0d cycles in test %0d", DONE_TIMEOUT, testId);
			timeouts++;
		end
		idleCycles(1);
	endtask

	// Back-to-back ops with an occasional gap and flag load
	task automatic runGroup(input int count, input int group, input int loadOdds);
		aluOp_t       o;
		logic [W-1:0] a, d;
		logic [31:0]  rnd;
		for (int i = 0; i < count; i++) begin
			pickOp(group, o);
			randomOperand(a);
			randomOperand(d);
			rnd = $random(seed);
			applyOp(o, rnd[0], a, d, (int'(rnd[15:8]) % loadOdds) == 0);
			if (rnd[4:2] == 3'd0)
				waitDone();
		end
		waitDone();
	endtask

	// Multiword ADDX/SUBX chains starting from Z set
	task automatic runChains(input int count);
		aluOp_t       o;
		logic [W-1:0] a, d;
		logic [31:0]  rnd;
		ccr_t         startFlags;
		for (int i = 0; i < count; i++) begin
			rnd                    = $random(seed);
			startFlags             = '0;
			startFlags[`ALU_ZF]    = 1'b1;
			startFlags[`ALU_XF]    = rnd[0];
			applyLoad(startFlags);
			for (int j = 0; j < 4; j++) begin
				rnd = $random(seed);
				pickOp(3, o);
				randomOperand(a);
				randomOperand(d);
				if (rnd[0]) begin           // Zero words test the sticky Z
					a = '0;
					d = '0;
				end
				applyOp(o, rnd[1], a, d, 1'b0);
			end
			waitDone();
		end
	endtask

	initial begin
		seed     = 32'h34468f8d;
		timeouts = 0;
		testId   = 3'd0;
		reset    = 1'b1;
		start    = 1'b0;
		op       = opAnd;
		isByte   = 1'b0;
		aOperand = '0;
		dOperand = '0;
		ccrLoad  = 1'b0;
		ccrIn    = '0;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;
		idleCycles(2);
		applyLoad(5'b10110);              // Direct flag load after reset
		idleCycles(2);
		testId = 3'd1;
		runGroup(200, 0, 16);
		testId = 3'd2;
		runGroup(300, 1, 16);
		testId = 3'd3;
		runChains(40);
		testId = 3'd4;
		runGroup(300, 2, 16);
		testId = 3'd5;
		runGroup(200, 4, 4);              // Mixed ops, frequent loads
		testId = 3'd6;
		idleCycles(2);
		$display("Totals: %0d checks, %0d errors, %0d timeouts", checkCount, errCount, timeouts);
		if (errCount == 0 && timeouts == 0 && checkCount > 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
hw/aluPkg.sv
hw/aluArith.sv
hw/aluShifter.sv
hw/aluFlagMerge.sv
hw/aluTop.sv
tb/aluChecker.sv
tb/aluTb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the ALU testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

# Lint warnings from the RTL are printed but do not stop the build
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
	--top-module aluTb -f sources.f -o aluSim

./obj_dir/aluSim | tee "$LOG"

if grep -q "^RESULT: PASS$" "$LOG"; then
	echo "Simulation passed, log in $LOG"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
